// ==== hdl/rs_pkg.sv ====
package rs_pkg;

    // widths
    typedef logic [31:0] data_t;
    typedef logic [5:0]  prn_t;

    // unit class an instruction needs
    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_kind_t;

    // alu function, ignored by the multiplier
    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_xor
    } alu_func_t;

    typedef struct packed {
        logic [$bits(data_t)-$bits(prn_t)-1:0] unused;
        prn_t                                  prn;    // tag sits in the low bits
    } tag_view_t;

    // operand word, the ready bit next to it picks the view
    typedef union packed {
        tag_view_t tag;     // still waiting on a producer
        data_t     value;   // operand is available
    } operand_t;

    typedef struct packed {
        logic      valid;
        fu_kind_t  fu;
        alu_func_t func;
        logic      op1_ready;
        logic      op2_ready;
        operand_t  op1;
        operand_t  op2;
        prn_t      dest_prn;
    } rs_entry_t;

    // defaults for the top level
    localparam int rs_size        = 8;
    localparam int dispatch_width = 2;

endpackage

// ==== hdl/psel_gen.sv ====
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
)(
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    // row r gets the r-th lowest set request bit
    always_comb begin
        int row;
        gnt_bus = '0;
        row     = 0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && row < REQS) begin
                gnt_bus[row][i] = 1'b1;
                row++;
            end
        end
    end

endmodule

// ==== hdl/rs.sv ====
`timescale 1ns/1ps

module rs
    import rs_pkg::*;
#(
    parameter int SIZE           = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int NUM_ALU        = 2,
    parameter int CDB_WIDTH      = 2,
    parameter int ALERT_DEPTH    = 2
)(
    input  logic                                clock,
    input  logic                                reset,

    // dispatch slots, filled from index 0 upward
    input  logic      [DISPATCH_WIDTH-1:0]      disp_valid,
    input  fu_kind_t  [DISPATCH_WIDTH-1:0]      disp_fu,
    input  alu_func_t [DISPATCH_WIDTH-1:0]      disp_func,
    input  logic      [DISPATCH_WIDTH-1:0]      disp_op1_ready,
    input  operand_t  [DISPATCH_WIDTH-1:0]      disp_op1,
    input  logic      [DISPATCH_WIDTH-1:0]      disp_op2_ready,
    input  operand_t  [DISPATCH_WIDTH-1:0]      disp_op2,
    input  prn_t      [DISPATCH_WIDTH-1:0]      disp_dest,

    input  logic      [CDB_WIDTH-1:0]           cdb_valid,
    input  prn_t      [CDB_WIDTH-1:0]           cdb_tag,
    input  data_t     [CDB_WIDTH-1:0]           cdb_value,

    input  logic      [NUM_ALU-1:0]             alu_avail,
    input  logic                                mult_avail,

    output logic      [NUM_ALU-1:0]             alu_issue,
    output alu_func_t [NUM_ALU-1:0]             alu_func,
    output data_t     [NUM_ALU-1:0]             alu_a,
    output data_t     [NUM_ALU-1:0]             alu_b,
    output prn_t      [NUM_ALU-1:0]             alu_dest,
    output logic                                mult_issue,
    output data_t                               mult_a,
    output data_t                               mult_b,
    output prn_t                                mult_dest,
    output logic                                almost_full
);

    localparam int CNT_W = $clog2(SIZE + 1);

    rs_entry_t [SIZE-1:0] entries;
    rs_entry_t [SIZE-1:0] next_entries;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     next_count;

    logic [SIZE-1:0] ready;
    logic [SIZE-1:0] alu_req;
    logic [SIZE-1:0] mult_req;

    logic [NUM_ALU-1:0][SIZE-1:0] alu_gnt_bus;
    logic [0:0][SIZE-1:0]         mult_gnt_bus;

    // both operands in, split by unit class
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            ready[i]    = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready;
            alu_req[i]  = ready[i] && (entries[i].fu == fu_alu);
            mult_req[i] = ready[i] && (entries[i].fu == fu_mult);
        end
    end

    psel_gen #(
        .WIDTH(SIZE),
        .REQS (NUM_ALU)
    ) alu_selector (
        .req    (alu_req),
        .gnt_bus(alu_gnt_bus)
    );

    psel_gen #(
        .WIDTH(SIZE),
        .REQS (1)
    ) mult_selector (
        .req    (mult_req),
        .gnt_bus(mult_gnt_bus)
    );

    always_comb begin
        int slot;
        next_entries = entries;
        next_count   = count;
        slot         = 0;
        alu_issue    = '0;
        alu_func     = {NUM_ALU{alu_add}};
        alu_a        = '0;
        alu_b        = '0;
        alu_dest     = '0;
        mult_issue   = 1'b0;
        mult_a       = '0;
        mult_b       = '0;
        mult_dest    = '0;

        for (int i = 0; i < SIZE; i++) begin
            // fill a free entry with the next dispatch slot
            if (!entries[i].valid && slot < DISPATCH_WIDTH && disp_valid[slot]) begin
                next_entries[i].valid     = 1'b1;
                next_entries[i].fu        = disp_fu[slot];
                next_entries[i].func      = disp_func[slot];
                next_entries[i].op1_ready = disp_op1_ready[slot];
                next_entries[i].op1       = disp_op1[slot];
                next_entries[i].op2_ready = disp_op2_ready[slot];
                next_entries[i].op2       = disp_op2[slot];
                next_entries[i].dest_prn  = disp_dest[slot];
                next_count                = next_count + 1'b1;
                slot++;
            end

            // cdb wake-up, also catches operands dispatched this cycle
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && next_entries[i].valid) begin
                    if (!next_entries[i].op1_ready
                        && next_entries[i].op1.tag.prn == cdb_tag[k]) begin
                        next_entries[i].op1.value = cdb_value[k];
                        next_entries[i].op1_ready = 1'b1;
                    end
                    if (!next_entries[i].op2_ready
                        && next_entries[i].op2.tag.prn == cdb_tag[k]) begin
                        next_entries[i].op2.value = cdb_value[k];
                        next_entries[i].op2_ready = 1'b1;
                    end
                end
            end

            // issue from the registered entry, grant dropped if the unit is busy
            for (int j = 0; j < NUM_ALU; j++) begin
                if (alu_gnt_bus[j][i] && alu_avail[j]) begin
                    alu_issue[j]          = 1'b1;
                    alu_func[j]           = entries[i].func;
                    alu_a[j]              = entries[i].op1.value;
                    alu_b[j]              = entries[i].op2.value;
                    alu_dest[j]           = entries[i].dest_prn;
                    next_entries[i].valid = 1'b0;
                    next_count            = next_count - 1'b1;
                end
            end

            if (mult_gnt_bus[0][i] && mult_avail) begin
                mult_issue            = 1'b1;
                mult_a                = entries[i].op1.value;
                mult_b                = entries[i].op2.value;
                mult_dest             = entries[i].dest_prn;
                next_entries[i].valid = 1'b0;
                next_count            = next_count - 1'b1;
            end
        end
    end

    assign almost_full = (count > SIZE - ALERT_DEPTH);

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            for (int i = 0; i < SIZE; i++) begin
                entries[i].valid <= 1'b0;   // payload left as is
            end
        end else begin
            count   <= next_count;
            entries <= next_entries;
        end
    end

endmodule

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
    import rs_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      issue,
    input  alu_func_t func,
    input  data_t     a,
    input  data_t     b,
    input  prn_t      dest,
    input  logic      grant,
    output logic      avail,
    output logic      done,
    output data_t     result,
    output prn_t      tag
);

    data_t alu_out;

    always_comb begin
        case (func)
            alu_add: alu_out = a + b;
            alu_sub: alu_out = a - b;
            alu_and: alu_out = a & b;
            default: alu_out = a ^ b;
        endcase
    end

    // free when empty or the held result leaves this cycle
    assign avail = !done || grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (issue) begin
            done <= 1'b1;   // back-to-back with the grant
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            result <= alu_out;
            tag    <= dest;
        end
    end

endmodule

// ==== hdl/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit
    import rs_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  issue,
    input  data_t a,
    input  data_t b,
    input  prn_t  dest,
    input  logic  grant,
    output logic  avail,
    output logic  done,
    output data_t result,
    output prn_t  tag
);

    logic        s1_valid;
    logic        s2_valid;
    data_t       s1_a;
    data_t       s1_b;
    prn_t        s1_tag;
    prn_t        s2_tag;
    data_t       s2_ll;       // low halves product
    logic [15:0] s2_cross;    // cross terms, low 16 bits only
    logic        stall;

    // last stage full and not taken holds the whole pipe
    assign stall = done && !grant;
    assign avail = !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            done     <= 1'b0;
        end else if (!stall) begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
            done     <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            s1_a     <= a;
            s1_b     <= b;
            s1_tag   <= dest;
            s2_ll    <= s1_a[15:0] * s1_b[15:0];
            s2_cross <= s1_a[15:0] * s1_b[31:16] + s1_a[31:16] * s1_b[15:0];
            s2_tag   <= s1_tag;
            result   <= s2_ll + {s2_cross, 16'h0000};   // low 32 of the product
            tag      <= s2_tag;
        end
    end

endmodule

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import rs_pkg::*;
#(
    parameter int NUM_ALU   = 2,
    parameter int CDB_WIDTH = 2
)(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   mult_done,
    input  data_t                  mult_result,
    input  prn_t                   mult_tag,
    input  logic  [NUM_ALU-1:0]    alu_done,
    input  data_t [NUM_ALU-1:0]    alu_result,
    input  prn_t  [NUM_ALU-1:0]    alu_tag,
    output logic                   mult_grant,
    output logic  [NUM_ALU-1:0]    alu_grant,
    output logic  [CDB_WIDTH-1:0]  cdb_valid,
    output prn_t  [CDB_WIDTH-1:0]  cdb_tag,
    output data_t [CDB_WIDTH-1:0]  cdb_value
);

    localparam int NREQ = NUM_ALU + 1;

    logic  [NREQ-1:0]      req;
    logic  [NREQ-1:0]      gnt;
    data_t [NREQ-1:0]      req_value;
    prn_t  [NREQ-1:0]      req_tag;
    logic  [CDB_WIDTH-1:0] next_valid;
    prn_t  [CDB_WIDTH-1:0] next_tag;
    data_t [CDB_WIDTH-1:0] next_value;

    // multiplier in bit 0 so it wins, then alu 0, alu 1
    assign req       = {alu_done, mult_done};
    assign req_value = {alu_result, mult_result};
    assign req_tag   = {alu_tag, mult_tag};

    always_comb begin
        int slot;
        gnt        = '0;
        next_valid = '0;
        next_tag   = '0;
        next_value = '0;
        slot       = 0;
        for (int r = 0; r < NREQ; r++) begin
            if (req[r] && slot < CDB_WIDTH) begin
                gnt[r]           = 1'b1;
                next_valid[slot] = 1'b1;
                next_tag[slot]   = req_tag[r];
                next_value[slot] = req_value[r];
                slot++;
            end
        end
    end

    assign mult_grant = gnt[0];
    assign alu_grant  = gnt[NREQ-1:1];

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= '0;
        end else begin
            cdb_valid <= next_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= next_tag;
        cdb_value <= next_value;
    end

endmodule

// ==== hdl/rs_top.sv ====
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
#(
    parameter int SIZE           = rs_size,
    parameter int DISPATCH_WIDTH = dispatch_width,
    parameter int NUM_ALU        = 2,
    parameter int CDB_WIDTH      = 2,
    parameter int ALERT_DEPTH    = dispatch_width
)(
    input  logic                           clock,
    input  logic                           reset,
    input  logic      [DISPATCH_WIDTH-1:0] disp_valid,
    input  fu_kind_t  [DISPATCH_WIDTH-1:0] disp_fu,
    input  alu_func_t [DISPATCH_WIDTH-1:0] disp_func,
    input  logic      [DISPATCH_WIDTH-1:0] disp_op1_ready,
    input  operand_t  [DISPATCH_WIDTH-1:0] disp_op1,
    input  logic      [DISPATCH_WIDTH-1:0] disp_op2_ready,
    input  operand_t  [DISPATCH_WIDTH-1:0] disp_op2,
    input  prn_t      [DISPATCH_WIDTH-1:0] disp_dest,
    output logic                           almost_full,
    output logic      [CDB_WIDTH-1:0]      cdb_valid,
    output prn_t      [CDB_WIDTH-1:0]      cdb_tag,
    output data_t     [CDB_WIDTH-1:0]      cdb_value
);

    // rs to units
    logic      [NUM_ALU-1:0] alu_issue;
    alu_func_t [NUM_ALU-1:0] alu_func;
    data_t     [NUM_ALU-1:0] alu_a;
    data_t     [NUM_ALU-1:0] alu_b;
    prn_t      [NUM_ALU-1:0] alu_dest;
    logic      [NUM_ALU-1:0] alu_avail;
    logic                    mult_issue;
    data_t                   mult_a;
    data_t                   mult_b;
    prn_t                    mult_dest;
    logic                    mult_avail;

    // units to arbiter
    logic  [NUM_ALU-1:0] alu_done;
    data_t [NUM_ALU-1:0] alu_result;
    prn_t  [NUM_ALU-1:0] alu_tag;
    logic  [NUM_ALU-1:0] alu_grant;
    logic                mult_done;
    data_t               mult_result;
    prn_t                mult_tag;
    logic                mult_grant;

    rs #(
        .SIZE          (SIZE),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .NUM_ALU       (NUM_ALU),
        .CDB_WIDTH     (CDB_WIDTH),
        .ALERT_DEPTH   (ALERT_DEPTH)
    ) u_rs (
        .clock         (clock),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp_fu       (disp_fu),
        .disp_func     (disp_func),
        .disp_op1_ready(disp_op1_ready),
        .disp_op1      (disp_op1),
        .disp_op2_ready(disp_op2_ready),
        .disp_op2      (disp_op2),
        .disp_dest     (disp_dest),
        .cdb_valid     (cdb_valid),     // loop back
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .alu_avail     (alu_avail),
        .mult_avail    (mult_avail),
        .alu_issue     (alu_issue),
        .alu_func      (alu_func),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_dest      (alu_dest),
        .mult_issue    (mult_issue),
        .mult_a        (mult_a),
        .mult_b        (mult_b),
        .mult_dest     (mult_dest),
        .almost_full   (almost_full)
    );

    for (genvar j = 0; j < NUM_ALU; j++) begin : g_alu
        alu_unit u_alu (
            .clock (clock),
            .reset (reset),
            .issue (alu_issue[j]),
            .func  (alu_func[j]),
            .a     (alu_a[j]),
            .b     (alu_b[j]),
            .dest  (alu_dest[j]),
            .grant (alu_grant[j]),
            .avail (alu_avail[j]),
            .done  (alu_done[j]),
            .result(alu_result[j]),
            .tag   (alu_tag[j])
        );
    end

    mult_unit u_mult (
        .clock (clock),
        .reset (reset),
        .issue (mult_issue),
        .a     (mult_a),
        .b     (mult_b),
        .dest  (mult_dest),
        .grant (mult_grant),
        .avail (mult_avail),
        .done  (mult_done),
        .result(mult_result),
        .tag   (mult_tag)
    );

    cdb_arbiter #(
        .NUM_ALU  (NUM_ALU),
        .CDB_WIDTH(CDB_WIDTH)
    ) u_cdb (
        .clock      (clock),
        .reset      (reset),
        .mult_done  (mult_done),
        .mult_result(mult_result),
        .mult_tag   (mult_tag),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .alu_tag    (alu_tag),
        .mult_grant (mult_grant),
        .alu_grant  (alu_grant),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value)
    );

endmodule

// ==== verification/rs_tb.sv ====
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();

    localparam int SIZE        = rs_size;
    localparam int ALERT_DEPTH = dispatch_width;
    localparam int NUM_INSTR   = 200;
    localparam int NUM_TAGS    = 64;

    logic                clock;
    logic                reset;
    logic      [1:0]     disp_valid;
    fu_kind_t  [1:0]     disp_fu;
    alu_func_t [1:0]     disp_func;
    logic      [1:0]     disp_op1_ready;
    operand_t  [1:0]     disp_op1;
    logic      [1:0]     disp_op2_ready;
    operand_t  [1:0]     disp_op2;
    prn_t      [1:0]     disp_dest;
    logic                almost_full;
    logic      [1:0]     cdb_valid;
    prn_t      [1:0]     cdb_tag;
    data_t     [1:0]     cdb_value;

    // program and reference values per instruction
    fu_kind_t  p_fu    [NUM_INSTR];
    alu_func_t p_func  [NUM_INSTR];
    int        p_src   [NUM_INSTR][2];   // -1 means immediate
    data_t     p_imm   [NUM_INSTR][2];
    data_t     p_value [NUM_INSTR];
    prn_t      p_tag   [NUM_INSTR];
    bit        p_seen  [NUM_INSTR];
    int        owner   [NUM_TAGS];       // live instruction per tag or -1

    logic [31:0] rng;
    int          in_flight;
    int          disp_now;
    int          seen_total;
    int          tag_ptr;
    bit          any_dispatched;

    rs_top #(
        .SIZE       (SIZE),
        .ALERT_DEPTH(ALERT_DEPTH)
    ) dut0 (
        .clock         (clock),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp_fu       (disp_fu),
        .disp_func     (disp_func),
        .disp_op1_ready(disp_op1_ready),
        .disp_op1      (disp_op1),
        .disp_op2_ready(disp_op2_ready),
        .disp_op2      (disp_op2),
        .disp_dest     (disp_dest),
        .almost_full   (almost_full),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected result from the unit rules
    function automatic data_t ref_result(fu_kind_t fu, alu_func_t func, data_t a, data_t b);
        if (fu == fu_mult) begin
            return a * b;   // low 32 bits
        end
        case (func)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic build_program();
        bit    burst;
        int    src;
        data_t opv [2];
        for (int i = 0; i < NUM_INSTR; i++) begin
            burst = ((i / 10) % 3) == 1;   // multiply-heavy stretch
            rng = xorshift(rng);
            p_fu[i]   = ((rng % 100) < (burst ? 70 : 15)) ? fu_mult : fu_alu;
            p_func[i] = alu_func_t'(rng[9:8]);
            for (int s = 0; s < 2; s++) begin
                rng = xorshift(rng);
                if (i > 0 && rng[1:0] != 2'b00) begin
                    src = i - 1 - int'(rng[7:4] % 6);
                    if (src < 0) begin
                        src = 0;
                    end
                    p_src[i][s] = src;
                    opv[s]      = p_value[src];
                end else begin
                    rng = xorshift(rng);
                    p_src[i][s] = -1;
                    p_imm[i][s] = rng;
                    opv[s]      = rng;
                end
            end
            p_value[i] = ref_result(p_fu[i], p_func[i], opv[0], opv[1]);
        end
    endtask

    task automatic clear_dispatch();
        disp_valid     = '0;
        disp_fu        = {2{fu_alu}};
        disp_func      = {2{alu_add}};
        disp_op1_ready = '0;
        disp_op1       = '0;
        disp_op2_ready = '0;
        disp_op2       = '0;
        disp_dest      = '0;
    endtask

    task automatic alloc_tag(output prn_t t);
        for (int n = 0; n < NUM_TAGS; n++) begin
            if (owner[(tag_ptr + n) % NUM_TAGS] < 0) begin
                t       = prn_t'((tag_ptr + n) % NUM_TAGS);
                tag_ptr = (tag_ptr + n + 1) % NUM_TAGS;
                return;
            end
        end
        fail_run("no free destination tag left for dispatch");
    endtask

    task automatic set_source(input int d, input int s, input int idx);
        int       src;
        logic     rdy;
        operand_t op;
        src = p_src[idx][s];
        op  = '0;
        if (src < 0) begin
            rdy      = 1'b1;
            op.value = p_imm[idx][s];
        end else if (p_seen[src]) begin
            rdy      = 1'b1;   // broadcast in an earlier cycle
            op.value = p_value[src];
        end else begin
            rdy        = 1'b0;   // woken from the cdb
            op.tag.prn = p_tag[src];
        end
        if (s == 0) begin
            disp_op1_ready[d] = rdy;
            disp_op1[d]       = op;
        end else begin
            disp_op2_ready[d] = rdy;
            disp_op2[d]       = op;
        end
    endtask

    task automatic load_slot(input int d, input int idx);
        prn_t t;
        alloc_tag(t);
        p_tag[idx]    = t;
        owner[t]      = idx;
        disp_valid[d] = 1'b1;
        disp_fu[d]    = p_fu[idx];
        disp_func[d]  = p_func[idx];
        disp_dest[d]  = t;
        set_source(d, 0, idx);
        set_source(d, 1, idx);
        in_flight++;
        disp_now++;
        any_dispatched = 1'b1;
    endtask

    task automatic check_broadcast(input int k);
        int   idx;
        prn_t t;
        t   = cdb_tag[k];
        idx = owner[t];
        assert (idx >= 0) else
            fail_run($sformatf("ERROR cdb_tag[%0d]: 0x%02h is not an outstanding tag", k, t));
        assert (cdb_value[k] == p_value[idx]) else
            fail_run($sformatf("ERROR cdb_value[%0d]: tag 0x%02h expected 0x%08h, got 0x%08h",
                               k, t, p_value[idx], cdb_value[k]));
        p_seen[idx] = 1'b1;
        owner[t]    = -1;
        in_flight--;
        seen_total++;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            for (int k = 0; k < 2; k++) begin
                if (cdb_valid[k]) begin
                    check_broadcast(k);
                end
            end
            // entries held by the rs are a subset of those dispatched and not broadcast
            assert (!almost_full || (in_flight - disp_now) > SIZE - ALERT_DEPTH) else
                fail_run($sformatf("ERROR almost_full: expected 0x0, got 0x%0h with %0d in flight",
                                   almost_full, in_flight - disp_now));
        end
    end

    assert property (@(posedge clock) disable iff (reset)
                     !any_dispatched |-> (cdb_valid == '0 && !almost_full))
        else fail_run($sformatf("ERROR cdb_valid/almost_full: expected 0x0/0x0, got 0x%0h/0x%0h",
                                $sampled(cdb_valid), $sampled(almost_full)));

    initial begin
        repeat (NUM_INSTR * 40) @(posedge clock);
        fail_run($sformatf("timeout after %0d cycles, %0d of %0d results reached the CDB",
                           NUM_INSTR * 40, seen_total, NUM_INSTR));
    end

    initial begin
        int i;
        int want;
        reset          = 1'b1;
        rng            = 32'd84;
        in_flight      = 0;
        disp_now       = 0;
        seen_total     = 0;
        tag_ptr        = 0;
        any_dispatched = 1'b0;
        clear_dispatch();
        for (int t = 0; t < NUM_TAGS; t++) begin
            owner[t] = -1;
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            p_seen[n] = 1'b0;
        end
        build_program();

        repeat (3) @(posedge clock);
        #1 reset = 1'b0;

        i = 0;
        while (i < NUM_INSTR) begin
            @(posedge clock);
            #1;
            clear_dispatch();
            disp_now = 0;
            if (!almost_full) begin
                rng  = xorshift(rng);
                want = (rng[1:0] == 2'b00) ? 0 : (rng[1:0] == 2'b01) ? 1 : 2;
                for (int d = 0; d < 2; d++) begin
                    if (d < want && i < NUM_INSTR) begin
                        load_slot(d, i);
                        i++;
                    end
                end
            end
        end
        @(posedge clock);
        #1;
        clear_dispatch();
        disp_now = 0;

        wait (seen_total == NUM_INSTR);
        repeat (5) @(posedge clock);   // catch late duplicates
        if (seen_total == NUM_INSTR && in_flight == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("result count mismatch, %0d seen and %0d still in flight",
                               seen_total, in_flight));
        end
    end

endmodule

// ==== rs_top.f ====
hdl/rs_pkg.sv
hdl/psel_gen.sv
hdl/rs.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/cdb_arbiter.sv
hdl/rs_top.sv
verification/rs_tb.sv

// ==== Bender.yml ====
package:
  name: rs_top

sources:
  - files:
      - hdl/rs_pkg.sv
      - hdl/psel_gen.sv
      - hdl/rs.sv
      - hdl/alu_unit.sv
      - hdl/mult_unit.sv
      - hdl/cdb_arbiter.sv
      - hdl/rs_top.sv
  - target: test
    files:
      - verification/rs_tb.sv
